// File: Bender.yml
package:
  name: sequencer_bridge

sources:
  - files:
      - source/seq_bridge_pkg.sv
      - source/slot_serializer.sv
      - source/read_deserializer.sv
      - source/sequencer_bridge.sv
  - target: test
    files:
      - verification/bridge_checker.sv
      - verification/tb_sequencer_bridge.sv

// File: list.f
source/seq_bridge_pkg.sv
source/slot_serializer.sv
source/read_deserializer.sv
source/sequencer_bridge.sv
verification/bridge_checker.sv
verification/tb_sequencer_bridge.sv

// File: source/read_deserializer.sv
`timescale 1ns/100ps
/* Pairs full-rate read slots into half-rate words with no back-pressure.
   Pairing restarts at every burst; a lone trailing slot is dropped. */
module read_deserializer (
	input  logic                                      seq_clk,
	input  logic                                      reset_n_seq_clk,

	input  logic [seq_bridge_pkg::afi_data_width-1:0] slot_data,
	input  logic                                      slot_valid,

	output seq_bridge_pkg::rd_word_t                  word_data,
	output logic                                      word_valid
);

	// Set while the first slot of a pair is held
	logic                                      phase;
	logic [seq_bridge_pkg::afi_data_width-1:0] first_slot;
	logic                                      pair_done;

	assign pair_done = slot_valid & phase;

	// Any gap in valid realigns pairing to the next burst start
	always_ff @(posedge seq_clk or negedge reset_n_seq_clk)
	begin
		if (~reset_n_seq_clk)
		begin
			phase      <= 1'b0;
			word_valid <= 1'b0;
		end
		else
		begin
			if (slot_valid)
			begin
				phase <= ~phase;
			end
			else
			begin
				phase <= 1'b0;
			end
			word_valid <= pair_done;
		end
	end

	always_ff @(posedge seq_clk)
	begin
		if (slot_valid && !phase)
		begin
			first_slot <= slot_data;
		end
		// First slot of the pair lands in the low half
		if (pair_done)
		begin
			word_data <= {slot_data, first_slot};
		end
	end

endmodule

// File: source/seq_bridge_pkg.sv
/* Slot widths and types for one full-rate AFI slot; half-rate ports are slots_per_word wide.
   Read enable is a single bit per slot. */
package seq_bridge_pkg;

	// Full-rate AFI slot widths
	localparam int afi_address_width = 13;
	localparam int afi_bank_width    = 3;
	localparam int afi_cs_width      = 1;
	localparam int afi_cke_width     = 1;
	localparam int afi_odt_width     = 1;
	localparam int afi_control_width = 1;
	localparam int afi_data_width    = 16;
	localparam int afi_dqs_width     = 2;
	localparam int afi_dm_width      = 2;

	// Rate ratio between the sequencer and the AFI side
	localparam int slots_per_word = 2;

	// One full-rate command slot
	typedef struct packed {
		logic [afi_address_width-1:0] address;
		logic [afi_bank_width-1:0]    bank;
		logic [afi_cs_width-1:0]      cs_n;
		logic [afi_cke_width-1:0]     cke;
		logic [afi_odt_width-1:0]     odt;
		logic [afi_control_width-1:0] ras_n;
		logic [afi_control_width-1:0] cas_n;
		logic [afi_control_width-1:0] we_n;
		logic                         rdata_en;
	} cmd_slot_t;

	// One full-rate write slot
	typedef struct packed {
		logic [afi_dqs_width-1:0]  dqs_en;
		logic [afi_data_width-1:0] wdata;
		logic [afi_dqs_width-1:0]  wdata_valid;
		logic [afi_dm_width-1:0]   dm;
	} wr_slot_t;

	// One half-rate read word, first slot of the pair in the low half
	typedef logic [slots_per_word*afi_data_width-1:0] rd_word_t;

	// A NOP slot deselects the chip and keeps RAS, CAS and WE high
	localparam cmd_slot_t cmd_idle = '{
		address:  '0,
		bank:     '0,
		cs_n:     '1,
		cke:      '0,
		odt:      '0,
		ras_n:    '1,
		cas_n:    '1,
		we_n:     '1,
		rdata_en: 1'b0
	};

	localparam wr_slot_t wr_idle = '0;

endpackage

// File: source/sequencer_bridge.sv
`timescale 1ns/100ps
/* Half-rate sequencer to full-rate AFI bridge in the seq_clk domain; low slot is sent first.
   Read data has no ready and must be taken as it arrives. */
module sequencer_bridge (
	input  logic seq_clk,
	input  logic reset_n_seq_clk,

	// Half-rate command pair from the sequencer
	input  logic seq_cmd_valid,
	output logic seq_cmd_ready,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_address_width-1:0] seq_address,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_bank_width-1:0]    seq_bank,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_cs_width-1:0]      seq_cs_n,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_cke_width-1:0]     seq_cke,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_odt_width-1:0]     seq_odt,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_control_width-1:0] seq_ras_n,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_control_width-1:0] seq_cas_n,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_control_width-1:0] seq_we_n,
	input  logic seq_rdata_en,

	// Half-rate write pair from the sequencer
	input  logic seq_wr_valid,
	output logic seq_wr_ready,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_dqs_width-1:0]  seq_dqs_en,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_data_width-1:0] seq_wdata,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_dqs_width-1:0]  seq_wdata_valid,
	input  logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_dm_width-1:0]   seq_dm,

	// Half-rate read words to the sequencer
	output logic [seq_bridge_pkg::slots_per_word*seq_bridge_pkg::afi_data_width-1:0] seq_rdata,
	output logic seq_rdata_valid,

	// Full-rate command slot to the PHY
	output logic afi_cmd_valid,
	input  logic afi_cmd_ready,
	output logic [seq_bridge_pkg::afi_address_width-1:0] mux_address,
	output logic [seq_bridge_pkg::afi_bank_width-1:0]    mux_bank,
	output logic [seq_bridge_pkg::afi_cs_width-1:0]      mux_cs_n,
	output logic [seq_bridge_pkg::afi_cke_width-1:0]     mux_cke,
	output logic [seq_bridge_pkg::afi_odt_width-1:0]     mux_odt,
	output logic [seq_bridge_pkg::afi_control_width-1:0] mux_ras_n,
	output logic [seq_bridge_pkg::afi_control_width-1:0] mux_cas_n,
	output logic [seq_bridge_pkg::afi_control_width-1:0] mux_we_n,
	output logic mux_rdata_en,

	// Full-rate write slot to the PHY
	output logic afi_wr_valid,
	input  logic afi_wr_ready,
	output logic [seq_bridge_pkg::afi_dqs_width-1:0]  mux_dqs_en,
	output logic [seq_bridge_pkg::afi_data_width-1:0] mux_wdata,
	output logic [seq_bridge_pkg::afi_dqs_width-1:0]  mux_wdata_valid,
	output logic [seq_bridge_pkg::afi_dm_width-1:0]   mux_dm,

	// Full-rate read slots from the PHY
	input  logic [seq_bridge_pkg::afi_data_width-1:0] mux_rdata,
	input  logic mux_rdata_valid
);

	seq_bridge_pkg::cmd_slot_t cmd_low;
	seq_bridge_pkg::cmd_slot_t cmd_high;
	seq_bridge_pkg::cmd_slot_t cmd_out;
	seq_bridge_pkg::wr_slot_t  wr_low;
	seq_bridge_pkg::wr_slot_t  wr_high;
	seq_bridge_pkg::wr_slot_t  wr_out;

	// Lower bits of each half-rate field form the low slot
	assign cmd_low = '{
		address:  seq_address[0 +: seq_bridge_pkg::afi_address_width],
		bank:     seq_bank[0 +: seq_bridge_pkg::afi_bank_width],
		cs_n:     seq_cs_n[0 +: seq_bridge_pkg::afi_cs_width],
		cke:      seq_cke[0 +: seq_bridge_pkg::afi_cke_width],
		odt:      seq_odt[0 +: seq_bridge_pkg::afi_odt_width],
		ras_n:    seq_ras_n[0 +: seq_bridge_pkg::afi_control_width],
		cas_n:    seq_cas_n[0 +: seq_bridge_pkg::afi_control_width],
		we_n:     seq_we_n[0 +: seq_bridge_pkg::afi_control_width],
		rdata_en: seq_rdata_en
	};

	assign cmd_high = '{
		address:  seq_address[seq_bridge_pkg::afi_address_width +: seq_bridge_pkg::afi_address_width],
		bank:     seq_bank[seq_bridge_pkg::afi_bank_width +: seq_bridge_pkg::afi_bank_width],
		cs_n:     seq_cs_n[seq_bridge_pkg::afi_cs_width +: seq_bridge_pkg::afi_cs_width],
		cke:      seq_cke[seq_bridge_pkg::afi_cke_width +: seq_bridge_pkg::afi_cke_width],
		odt:      seq_odt[seq_bridge_pkg::afi_odt_width +: seq_bridge_pkg::afi_odt_width],
		ras_n:    seq_ras_n[seq_bridge_pkg::afi_control_width +: seq_bridge_pkg::afi_control_width],
		cas_n:    seq_cas_n[seq_bridge_pkg::afi_control_width +: seq_bridge_pkg::afi_control_width],
		we_n:     seq_we_n[seq_bridge_pkg::afi_control_width +: seq_bridge_pkg::afi_control_width],
		rdata_en: seq_rdata_en
	};

	assign wr_low = '{
		dqs_en:      seq_dqs_en[0 +: seq_bridge_pkg::afi_dqs_width],
		wdata:       seq_wdata[0 +: seq_bridge_pkg::afi_data_width],
		wdata_valid: seq_wdata_valid[0 +: seq_bridge_pkg::afi_dqs_width],
		dm:          seq_dm[0 +: seq_bridge_pkg::afi_dm_width]
	};

	assign wr_high = '{
		dqs_en:      seq_dqs_en[seq_bridge_pkg::afi_dqs_width +: seq_bridge_pkg::afi_dqs_width],
		wdata:       seq_wdata[seq_bridge_pkg::afi_data_width +: seq_bridge_pkg::afi_data_width],
		wdata_valid: seq_wdata_valid[seq_bridge_pkg::afi_dqs_width +: seq_bridge_pkg::afi_dqs_width],
		dm:          seq_dm[seq_bridge_pkg::afi_dm_width +: seq_bridge_pkg::afi_dm_width]
	};

	slot_serializer #(
		.slot_t    (seq_bridge_pkg::cmd_slot_t),
		.idle_slot (seq_bridge_pkg::cmd_idle)
	) u_cmd_serializer (
		.seq_clk         (seq_clk),
		.reset_n_seq_clk (reset_n_seq_clk),
		.in_valid        (seq_cmd_valid),
		.in_ready        (seq_cmd_ready),
		.in_low          (cmd_low),
		.in_high         (cmd_high),
		.out_valid       (afi_cmd_valid),
		.out_ready       (afi_cmd_ready),
		.out_slot        (cmd_out)
	);

	slot_serializer #(
		.slot_t    (seq_bridge_pkg::wr_slot_t),
		.idle_slot (seq_bridge_pkg::wr_idle)
	) u_wr_serializer (
		.seq_clk         (seq_clk),
		.reset_n_seq_clk (reset_n_seq_clk),
		.in_valid        (seq_wr_valid),
		.in_ready        (seq_wr_ready),
		.in_low          (wr_low),
		.in_high         (wr_high),
		.out_valid       (afi_wr_valid),
		.out_ready       (afi_wr_ready),
		.out_slot        (wr_out)
	);

	read_deserializer u_read_deserializer (
		.seq_clk         (seq_clk),
		.reset_n_seq_clk (reset_n_seq_clk),
		.slot_data       (mux_rdata),
		.slot_valid      (mux_rdata_valid),
		.word_data       (seq_rdata),
		.word_valid      (seq_rdata_valid)
	);

	assign mux_address  = cmd_out.address;
	assign mux_bank     = cmd_out.bank;
	assign mux_cs_n     = cmd_out.cs_n;
	assign mux_cke      = cmd_out.cke;
	assign mux_odt      = cmd_out.odt;
	assign mux_ras_n    = cmd_out.ras_n;
	assign mux_cas_n    = cmd_out.cas_n;
	assign mux_we_n     = cmd_out.we_n;
	assign mux_rdata_en = cmd_out.rdata_en;

	assign mux_dqs_en      = wr_out.dqs_en;
	assign mux_wdata       = wr_out.wdata;
	assign mux_wdata_valid = wr_out.wdata_valid;
	assign mux_dm          = wr_out.dm;

endmodule

// File: source/slot_serializer.sv
`timescale 1ns/100ps
/* Sends an accepted slot pair as two full-rate slots, low first; one pair per two cycles at most.
   out_slot shows idle_slot while out_valid is low. */
module slot_serializer #(
	parameter type   slot_t    = logic,
	parameter slot_t idle_slot = '0
)(
	input  logic  seq_clk,
	input  logic  reset_n_seq_clk,

	input  logic  in_valid,
	output logic  in_ready,
	input  slot_t in_low,
	input  slot_t in_high,

	output logic  out_valid,
	input  logic  out_ready,
	output slot_t out_slot
);

	// Counts the slots of the current pair still to be taken and is 2 while the low slot shows
	logic  [1:0] slot_cnt;
	slot_t       cur_slot;
	slot_t       high_slot;
	logic        accept;
	logic        take;

	assign out_valid = (slot_cnt != 2'd0);
	assign take      = out_valid & out_ready;

	// A new pair may enter as the high slot of the previous one leaves
	assign in_ready = (slot_cnt == 2'd0) | ((slot_cnt == 2'd1) & out_ready);
	assign accept   = in_valid & in_ready;

	assign out_slot = out_valid ? cur_slot : idle_slot;

	always_ff @(posedge seq_clk or negedge reset_n_seq_clk)
	begin
		if (~reset_n_seq_clk)
		begin
			slot_cnt <= 2'd0;
		end
		else if (accept)
		begin
			slot_cnt <= 2'd2;
		end
		else if (take)
		begin
			slot_cnt <= slot_cnt - 2'd1;
		end
	end

	// Low slot goes straight to the output register, high slot waits its turn
	always_ff @(posedge seq_clk)
	begin
		if (accept)
		begin
			cur_slot  <= in_low;
			high_slot <= in_high;
		end
		else if (take && (slot_cnt == 2'd2))
		begin
			cur_slot <= high_slot;
		end
	end

endmodule

// File: verification/bridge_checker.sv
`timescale 1ns/100ps
/* Watches the bridge ports and compares them with reference slot streams and read words.
   Inputs are sampled on the rising edge of seq_clk, before the DUT registers update. */
module bridge_checker (
	input logic        seq_clk,
	input logic        reset_n_seq_clk,
	input logic        stim_on,
	input logic        odd_bursts,
	input logic        seq_cmd_valid,
	input logic        seq_cmd_ready,
	input logic [44:0] cmd_fields,
	input logic        afi_cmd_valid,
	input logic        afi_cmd_ready,
	input logic [22:0] cmd_slot,
	input logic        seq_wr_valid,
	input logic        seq_wr_ready,
	input logic [43:0] wr_fields,
	input logic        afi_wr_valid,
	input logic        afi_wr_ready,
	input logic [21:0] wr_slot,
	input logic [15:0] mux_rdata,
	input logic        mux_rdata_valid,
	input logic [31:0] seq_rdata,
	input logic        seq_rdata_valid
);

	int          checks [6];
	int          errors [6];
	int          check_total;
	int          error_total;
	logic [22:0] cmd_q [$];
	logic [21:0] wr_q [$];
	logic [31:0] rd_q [$];
	logic        cmd_stalled;
	logic        wr_stalled;
	logic [22:0] cmd_held;
	logic [21:0] wr_held;
	logic        rd_phase;
	logic [15:0] rd_first;

	function automatic string test_name(input int t);
		case (t)
			0: return "reset_idle";
			1: return "cmd_order";
			2: return "wr_order";
			3: return "back_pressure";
			4: return "read_pairing";
			default: return "odd_burst";
		endcase
	endfunction

	// Slot s of a pair takes the bits of half s of every field; rdata_en goes to both slots
	function automatic logic [22:0] cmd_slot_ref(input logic [44:0] f, input int s);
		return {f[19+13*s +: 13], f[13+3*s +: 3], f[11+s], f[9+s], f[7+s], f[5+s], f[3+s],
			f[1+s], f[0]};
	endfunction

	function automatic logic [21:0] wr_slot_ref(input logic [43:0] f, input int s);
		return {f[40+2*s +: 2], f[8+16*s +: 16], f[4+2*s +: 2], f[2*s +: 2]};
	endfunction

	// The first slot of a pair is the low half of the word
	function automatic logic [31:0] rd_word_ref(input logic [15:0] first, input logic [15:0] second);
		return {second, first};
	endfunction

	task automatic fault(input int t, input string msg);
		checks[t]++;
		check_total++;
		errors[t]++;
		error_total++;
		$display("%s: %s", test_name(t), msg);
	endtask

	task automatic compare(input int t, input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks[t]++;
		check_total++;
		if (expected !== actual)
		begin
			errors[t]++;
			error_total++;
			$display("FAIL %s: %s expected %0h actual %0h", test_name(t), what, expected, actual);
		end
	endtask

	task automatic report_test(input int t);
		if ((t == 1 && cmd_q.size() != 0) || (t == 2 && wr_q.size() != 0) ||
			(t >= 4 && rd_q.size() != 0))
			fault(t, "expected output never appeared");
		$display("%s done: %0d checks, %0d errors", test_name(t), checks[t], errors[t]);
	endtask

	always @(posedge seq_clk)
	begin
		if (!reset_n_seq_clk)
		begin
			cmd_stalled = 1'b0;
			wr_stalled  = 1'b0;
			rd_phase    = 1'b0;
		end
		else
		begin
			if (!stim_on)
				compare(0, "valids and slots", 64'({3'b000, 23'h00004e, 22'h000000}),
					64'({afi_cmd_valid, afi_wr_valid, seq_rdata_valid, cmd_slot, wr_slot}));
			if (cmd_stalled)
				compare(3, "held command slot", 64'({1'b1, cmd_held}), 64'({afi_cmd_valid, cmd_slot}));
			if (wr_stalled)
				compare(3, "held write slot", 64'({1'b1, wr_held}), 64'({afi_wr_valid, wr_slot}));
			// Nothing may be left of the previous pair once this edge has taken its slot
			if (seq_cmd_valid && seq_cmd_ready)
				compare(3, "command slots left at accept", 64'(0),
					64'(cmd_q.size() - int'(afi_cmd_valid && afi_cmd_ready)));
			if (seq_wr_valid && seq_wr_ready)
				compare(3, "write slots left at accept", 64'(0),
					64'(wr_q.size() - int'(afi_wr_valid && afi_wr_ready)));
			if (afi_cmd_valid && afi_cmd_ready && cmd_q.size() == 0)
				fault(1, "command slot taken with no pair pending");
			else if (afi_cmd_valid && afi_cmd_ready)
				compare(1, "command slot", 64'(cmd_q.pop_front()), 64'(cmd_slot));
			else if (!afi_cmd_valid)
				compare(1, "idle command slot", 64'(23'h00004e), 64'(cmd_slot));
			if (afi_wr_valid && afi_wr_ready && wr_q.size() == 0)
				fault(2, "write slot taken with no pair pending");
			else if (afi_wr_valid && afi_wr_ready)
				compare(2, "write slot", 64'(wr_q.pop_front()), 64'(wr_slot));
			else if (!afi_wr_valid)
				compare(2, "idle write slot", 64'(0), 64'(wr_slot));
			if (seq_cmd_valid && seq_cmd_ready)
			begin
				cmd_q.push_back(cmd_slot_ref(cmd_fields, 0));
				cmd_q.push_back(cmd_slot_ref(cmd_fields, 1));
			end
			if (seq_wr_valid && seq_wr_ready)
			begin
				wr_q.push_back(wr_slot_ref(wr_fields, 0));
				wr_q.push_back(wr_slot_ref(wr_fields, 1));
			end
			if (seq_rdata_valid && rd_q.size() == 0)
				fault(odd_bursts ? 5 : 4, "read word appeared with no complete pair behind it");
			else if (seq_rdata_valid)
				compare(odd_bursts ? 5 : 4, "read word", 64'(rd_q.pop_front()), 64'(seq_rdata));
			// A gap in mux_rdata_valid drops a half-built pair
			if (mux_rdata_valid && rd_phase)
				rd_q.push_back(rd_word_ref(rd_first, mux_rdata));
			else if (mux_rdata_valid)
				rd_first = mux_rdata;
			rd_phase    = mux_rdata_valid && !rd_phase;
			cmd_stalled = afi_cmd_valid && !afi_cmd_ready;
			cmd_held    = cmd_slot;
			wr_stalled  = afi_wr_valid && !afi_wr_ready;
			wr_held     = wr_slot;
		end
	end

endmodule

// File: verification/tb_sequencer_bridge.sv
`timescale 1ns/100ps
/* Random command and write pairs under AFI stalls, then even and odd read bursts.
   Inputs change 1 ns after the rising edge; a cycle limit ends a stuck run. */
module tb_sequencer_bridge;

	localparam int pair_count  = 200;
	localparam int read_cycles = 400;
	// Up to 8 cycles per pair plus the read bursts, rounded up to whole thousands
	localparam int timeout_cycles = ((pair_count * 8 + read_cycles) / 1000 + 1) * 1000;

	int unsigned rnd_seed;
	int          cycle_count = 0;
	logic        seq_clk;
	logic        reset_n_seq_clk;
	logic        stim_on;
	logic        odd_bursts;
	logic        seq_cmd_valid;
	wire         seq_cmd_ready;
	logic [44:0] cmd_fields;
	wire         afi_cmd_valid;
	logic        afi_cmd_ready;
	wire  [22:0] cmd_slot;
	logic        seq_wr_valid;
	wire         seq_wr_ready;
	logic [43:0] wr_fields;
	wire         afi_wr_valid;
	logic        afi_wr_ready;
	wire  [21:0] wr_slot;
	logic [15:0] mux_rdata;
	logic        mux_rdata_valid;
	wire  [31:0] seq_rdata;
	wire         seq_rdata_valid;

	sequencer_bridge u_sequencer_bridge (
		.seq_clk         (seq_clk),
		.reset_n_seq_clk (reset_n_seq_clk),
		.seq_cmd_valid   (seq_cmd_valid),
		.seq_cmd_ready   (seq_cmd_ready),
		.seq_address     (cmd_fields[44:19]),
		.seq_bank        (cmd_fields[18:13]),
		.seq_cs_n        (cmd_fields[12:11]),
		.seq_cke         (cmd_fields[10:9]),
		.seq_odt         (cmd_fields[8:7]),
		.seq_ras_n       (cmd_fields[6:5]),
		.seq_cas_n       (cmd_fields[4:3]),
		.seq_we_n        (cmd_fields[2:1]),
		.seq_rdata_en    (cmd_fields[0]),
		.seq_wr_valid    (seq_wr_valid),
		.seq_wr_ready    (seq_wr_ready),
		.seq_dqs_en      (wr_fields[43:40]),
		.seq_wdata       (wr_fields[39:8]),
		.seq_wdata_valid (wr_fields[7:4]),
		.seq_dm          (wr_fields[3:0]),
		.seq_rdata       (seq_rdata),
		.seq_rdata_valid (seq_rdata_valid),
		.afi_cmd_valid   (afi_cmd_valid),
		.afi_cmd_ready   (afi_cmd_ready),
		.mux_address     (cmd_slot[22:10]),
		.mux_bank        (cmd_slot[9:7]),
		.mux_cs_n        (cmd_slot[6]),
		.mux_cke         (cmd_slot[5]),
		.mux_odt         (cmd_slot[4]),
		.mux_ras_n       (cmd_slot[3]),
		.mux_cas_n       (cmd_slot[2]),
		.mux_we_n        (cmd_slot[1]),
		.mux_rdata_en    (cmd_slot[0]),
		.afi_wr_valid    (afi_wr_valid),
		.afi_wr_ready    (afi_wr_ready),
		.mux_dqs_en      (wr_slot[21:20]),
		.mux_wdata       (wr_slot[19:4]),
		.mux_wdata_valid (wr_slot[3:2]),
		.mux_dm          (wr_slot[1:0]),
		.mux_rdata       (mux_rdata),
		.mux_rdata_valid (mux_rdata_valid)
	);

	bridge_checker u_checker (.*);

	initial
	begin
		seq_clk = 1'b0;
		forever #2 seq_clk = ~seq_clk;
	end

	always @(posedge seq_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Each pair holds until it is taken; the AFI side stalls about one cycle in four
	task automatic drive_pairs(input int count);
		int   cmd_sent;
		int   wr_sent;
		logic cmd_acc;
		logic wr_acc;
		cmd_sent = 0;
		wr_sent  = 0;
		while (cmd_sent < count || wr_sent < count)
		begin
			@(posedge seq_clk);
			cmd_acc = seq_cmd_valid & seq_cmd_ready;
			wr_acc  = seq_wr_valid & seq_wr_ready;
			if (cmd_acc)
				cmd_sent++;
			if (wr_acc)
				wr_sent++;
			#1;
			afi_cmd_ready = ($urandom % 4) != 0;
			afi_wr_ready  = ($urandom % 4) != 0;
			if (cmd_acc || !seq_cmd_valid)
			begin
				seq_cmd_valid = (cmd_sent < count) && (($urandom % 4) != 0);
				cmd_fields    = 45'({$urandom, $urandom});
			end
			if (wr_acc || !seq_wr_valid)
			begin
				seq_wr_valid = (wr_sent < count) && (($urandom % 4) != 0);
				wr_fields    = 44'({$urandom, $urandom});
			end
		end
		afi_cmd_ready = 1'b1;
		afi_wr_ready  = 1'b1;
	endtask

	task automatic drive_read_bursts(input int bursts, input logic odd_lengths);
		int len;
		for (int i = 0; i < bursts; i++)
		begin
			if (odd_lengths)
				len = (i % 2 == 0) ? 1 + 2 * ($urandom % 4) : 1 + $urandom % 8;
			else
				len = 2 + 2 * ($urandom % 4);
			repeat (len)
			begin
				mux_rdata_valid = 1'b1;
				mux_rdata       = 16'($urandom);
				@(posedge seq_clk);
				#1;
			end
			mux_rdata_valid = 1'b0;
			repeat (1 + $urandom % 3) @(posedge seq_clk);
			#1;
		end
	endtask

	initial
	begin
		rnd_seed = 32'ha530197e;
		void'($urandom(rnd_seed));
		reset_n_seq_clk = 1'b0;
		stim_on         = 1'b0;
		odd_bursts      = 1'b0;
		seq_cmd_valid   = 1'b0;
		seq_wr_valid    = 1'b0;
		cmd_fields      = '0;
		wr_fields       = '0;
		afi_cmd_ready   = 1'b0;
		afi_wr_ready    = 1'b0;
		mux_rdata       = '0;
		mux_rdata_valid = 1'b0;
		repeat (4) @(posedge seq_clk);
		#1;
		reset_n_seq_clk = 1'b1;
		repeat (3) @(posedge seq_clk);
		#1;
		u_checker.report_test(0);
		stim_on = 1'b1;
		drive_pairs(pair_count);
		while (afi_cmd_valid || afi_wr_valid) @(posedge seq_clk);
		repeat (2) @(posedge seq_clk);
		#1;
		u_checker.report_test(1);
		u_checker.report_test(2);
		u_checker.report_test(3);
		drive_read_bursts(20, 1'b0);
		repeat (3) @(posedge seq_clk);
		#1;
		u_checker.report_test(4);
		odd_bursts = 1'b1;
		drive_read_bursts(15, 1'b1);
		repeat (3) @(posedge seq_clk);
		#1;
		u_checker.report_test(5);
		$display("Totals: %0d checks, %0d errors", u_checker.check_total, u_checker.error_total);
		if (u_checker.error_total == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
